// File: flist.f
logic/rv_pkg.sv
logic/pipe_ifs.sv
logic/rv_shifter.sv
logic/rv_alu.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core.sv
tests/rv_core_assert.sv
tests/tb_rv_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f flist.f

# The simulator exits non-zero on a fatal error, the search below decides the result
output=$(./obj_dir/Vtb_rv_core 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

// File: tests/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 2000;
    // Random phase takes at most two cycles per instruction, the rest is short
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * NUM_RANDOM + 200;

    typedef struct packed {
        int unsigned cycle;
        logic        valid;
        reg_addr_t   rd;
        xlen_t       data;
    } expect_t;

    logic      clk;
    logic      rst;
    logic      instr_valid_i;
    instr_t    instr_i;
    logic      wb_valid_o;
    reg_addr_t wb_rd_o;
    xlen_t     wb_data_o;

    xlen_t       model_regs [NUM_REGS];
    expect_t     expect_q [$];
    int unsigned cycle_cnt;

    rv_core DUT (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic xlen_t reg_value(input reg_addr_t idx);
        return (idx == '0) ? '0 : model_regs[idx];
    endfunction

    // alt selects SUB over ADD and SRA over SRL
    function automatic xlen_t ref_op64(input logic [2:0] funct3, input logic alt,
                                       input xlen_t a, input xlen_t b);
        case (funct3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[5:0];
            3'b010: return {63'b0, $signed(a) < $signed(b)};
            3'b011: return {63'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic xlen_t ref_op32(input logic [2:0] funct3, input logic alt,
                                       input xlen_t a, input xlen_t b);
        logic [31:0] w;
        case (funct3)
            3'b000: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'b001: w = a[31:0] << b[4:0];
            default: begin
                if (alt) begin
                    w = $signed(a[31:0]) >>> b[4:0];
                end else begin
                    w = a[31:0] >> b[4:0];
                end
            end
        endcase
        return {{32{w[31]}}, w};
    endfunction

    // Returns whether the instruction writes a register, result through the output
    function automatic logic ref_execute(input instr_t instr, output xlen_t result);
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic       alt;
        logic       shift;
        logic       ok;
        xlen_t      a;
        xlen_t      b;
        opcode = instr[6:0];
        funct3 = instr[14:12];
        funct7 = instr[31:25];
        a      = reg_value(instr[19:15]);
        b      = {{52{instr[31]}}, instr[31:20]};
        if (opcode == OPCODE_OP || opcode == OPCODE_OP_32) begin
            b = reg_value(instr[24:20]);
        end
        result = '0;
        ok     = 1'b0;
        case (opcode)
            OPCODE_LUI: begin
                result = {{32{instr[31]}}, instr[31:12], 12'b0};
                ok     = 1'b1;
            end
            OPCODE_OP_IMM: begin
                shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
                alt    = (funct3 == 3'b101) && instr[30];
                ok     = !shift || (instr[31:26] == {1'b0, alt, 4'b0000});
                result = ref_op64(funct3, alt, a, b);
            end
            OPCODE_OP_IMM_32: begin
                shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
                alt    = (funct3 == 3'b101) && instr[30];
                ok     = (funct3 == 3'b000) || (shift && (funct7 == {1'b0, alt, 5'b0}));
                result = ref_op32(funct3, alt, a, b);
            end
            OPCODE_OP: begin
                alt    = (funct7 == 7'b0100000);
                ok     = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
                result = ref_op64(funct3, alt, a, b);
            end
            OPCODE_OP_32: begin
                alt    = (funct7 == 7'b0100000);
                shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
                ok     = ((funct3 == 3'b000) || shift) &&
                         ((funct7 == 7'b0) || (alt && funct3 != 3'b001));
                result = ref_op32(funct3, alt, a, b);
            end
            default: ok = 1'b0;
        endcase
        return ok && (instr[11:7] != 5'd0);
    endfunction

    //////////////////////////////////////////////////
    // Encoding and stimulus
    //////////////////////////////////////////////////

    function automatic instr_t enc_r(input logic [6:0] opcode, input reg_addr_t rd,
                                     input logic [2:0] funct3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [6:0] funct7);
        return {funct7, rs2, rs1, funct3, rd, opcode};
    endfunction

    function automatic instr_t enc_i(input logic [6:0] opcode, input reg_addr_t rd,
                                     input logic [2:0] funct3, input reg_addr_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic instr_t enc_u(input logic [6:0] opcode, input reg_addr_t rd,
                                     input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    // Model is updated at issue, in order, so later issues see the new value
    task automatic issue(input instr_t instr);
        expect_t entry;
        xlen_t   result;
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        entry.cycle   = cycle_cnt + 1;
        entry.valid   = ref_execute(instr, result);
        entry.rd      = instr[11:7];
        entry.data    = result;
        expect_q.push_back(entry);
        if (entry.valid) begin
            model_regs[instr[11:7]] = result;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            instr_valid_i = 1'b0;
            instr_i       = $urandom;
        end
    endtask

    task automatic load_known();
        for (int r = 1; r < NUM_REGS; r++) begin
            issue(enc_u(OPCODE_LUI, reg_addr_t'(r), 20'($urandom)));
            issue(enc_i(OPCODE_OP_IMM, reg_addr_t'(r), 3'b000, reg_addr_t'(r), 12'($urandom)));
        end
        idle(3);
    endtask

    // Each instruction reads the one just before it
    task automatic bypass_chain();
        issue(enc_i(OPCODE_OP_IMM, 5'd5, 3'b000, 5'd0, 12'h5a3));
        issue(enc_r(OPCODE_OP, 5'd6, 3'b000, 5'd5, 5'd5, 7'b0000000));
        issue(enc_r(OPCODE_OP, 5'd7, 3'b000, 5'd6, 5'd5, 7'b0100000));
        issue(enc_r(OPCODE_OP_32, 5'd7, 3'b001, 5'd7, 5'd6, 7'b0000000));
        issue(enc_i(OPCODE_OP_IMM, 5'd8, 3'b101, 5'd7, 12'h403));
        issue(enc_r(OPCODE_OP, 5'd9, 3'b011, 5'd0, 5'd8, 7'b0000000));
        issue(enc_r(OPCODE_OP, 5'd9, 3'b010, 5'd8, 5'd9, 7'b0000000));
        idle(2);
    endtask

    task automatic random_ops();
        reg_addr_t   prev_rd;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] imm;
        int unsigned kind;
        prev_rd = 5'd1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rd     = 5'($urandom_range(31, 1));
            rs1    = ($urandom_range(1, 0) == 1) ? prev_rd : 5'($urandom);
            rs2    = ($urandom_range(3, 0) == 0) ? prev_rd : 5'($urandom);
            funct3 = 3'($urandom);
            funct7 = ($urandom_range(1, 0) == 1) ? 7'b0100000 : 7'b0000000;
            imm    = 12'($urandom);
            kind   = $urandom_range(4, 0);
            case (kind)
                0: issue(enc_r(OPCODE_OP, rd, funct3, rs1, rs2, funct7));
                1: issue(enc_r(OPCODE_OP_32, rd, funct3, rs1, rs2, funct7));
                2: begin
                    if (funct3 == 3'b001 || funct3 == 3'b101) begin
                        imm[11:6] = {1'b0, funct7[5], 4'b0000};
                    end
                    issue(enc_i(OPCODE_OP_IMM, rd, funct3, rs1, imm));
                end
                3: begin
                    if (funct3 == 3'b001 || funct3 == 3'b101) begin
                        imm[11:5] = funct7;
                    end
                    issue(enc_i(OPCODE_OP_IMM_32, rd, funct3, rs1, imm));
                end
                default: issue(enc_u(OPCODE_LUI, rd, 20'($urandom)));
            endcase
            prev_rd = rd;
            if ($urandom_range(7, 0) == 0) begin
                idle(1);
            end
        end
        idle(2);
    endtask

    task automatic no_write_cases();
        issue(enc_i(OPCODE_OP_IMM, 5'd0, 3'b000, 5'd1, 12'h123));
        issue(enc_r(OPCODE_OP, 5'd0, 3'b000, 5'd2, 5'd3, 7'b0000000));
        // Load, branch, system and AUIPC are outside the kept set
        issue(enc_i(7'b0000011, 5'd4, 3'b011, 5'd1, 12'h010));
        issue(enc_i(7'b1100011, 5'd4, 3'b000, 5'd1, 12'h008));
        issue(enc_i(7'b1110011, 5'd4, 3'b000, 5'd0, 12'h000));
        issue(enc_u(7'b0010111, 5'd4, 20'h12345));
        idle(3);
        issue(enc_r(OPCODE_OP, 5'd10, 3'b000, 5'd0, 5'd0, 7'b0000000));
        issue(enc_r(OPCODE_OP, 5'd11, 3'b110, 5'd0, 5'd10, 7'b0000000));
        issue(enc_i(OPCODE_OP_IMM, 5'd12, 3'b000, 5'd0, 12'h000));
    endtask

    //////////////////////////////////////////////////
    // Comparison, watchdog and main sequence
    //////////////////////////////////////////////////

    // Outputs are sampled on the falling edge, two rising edges after issue
    always @(negedge clk) begin
        expect_t entry;
        if (expect_q.size() > 0 && expect_q[0].cycle + 2 == cycle_cnt) begin
            entry = expect_q.pop_front();
            check_value("wb_valid_o", xlen_t'(wb_valid_o), xlen_t'(entry.valid));
            if (entry.valid) begin
                check_value("wb_rd_o", xlen_t'(wb_rd_o), xlen_t'(entry.rd));
                check_value("wb_data_o", wb_data_o, entry.data);
            end
        end else begin
            check_value("wb_valid_o", xlen_t'(wb_valid_o), '0);
        end
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the run did not reach its end in time");
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cycle_cnt     = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(32'hd136));

        // Strobes during reset must not reach the writeback
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            instr_valid_i = 1'b1;
            instr_i       = enc_u(OPCODE_LUI, 5'($urandom_range(31, 1)), 20'($urandom));
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
        rst           = 1'b1;

        idle(8);
        load_known();
        bypass_chain();
        random_ops();
        no_write_cases();
        idle(6);

        if (expect_q.size() != 0) begin
            abort_run("Expected writebacks are still outstanding at the end of the run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: tests/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
    input logic              clk,
    input logic              rst,
    input logic              instr_valid_i,
    input logic              wb_valid_i,
    input rv_pkg::reg_addr_t wb_rd_i
);

    // No writeback while the core is held in reset
    reset_quiet: assert property (@(posedge clk) !rst |-> !wb_valid_i)
        else $error("Writeback valid while reset is active");

    // The decoder turns every x0 destination into a bubble
    no_x0_write: assert property (@(posedge clk) disable iff (!rst)
        wb_valid_i |-> (wb_rd_i != '0))
        else $error("Writeback to register x0");

    // Strobe sampled at edge N is seen as a writeback at edge N+3
    strobe_origin: assert property (@(posedge clk) disable iff (!rst)
        wb_valid_i |-> $past(instr_valid_i, 3))
        else $error("Writeback without a matching instruction strobe");

endmodule

bind rv_core rv_core_assert u_core_assert (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o)
);

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid_i,
    input  rv_pkg::instr_t    instr_i,
    output logic              wb_valid_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::xlen_t     wb_data_o
);

    decode_bus_if dec_bus ();
    reg_read_if   rd_bus ();

    rv_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_o         (dec_bus)
    );

    // Writeback port drives both the file and the top level
    rv_execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .dec_i   (dec_bus),
        .rd_o    (rd_bus),
        .we_o    (wb_valid_o),
        .waddr_o (wb_rd_o),
        .wdata_o (wb_data_o)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rd_i    (rd_bus),
        .we_i    (wb_valid_o),
        .waddr_i (wb_rd_o),
        .wdata_i (wb_data_o)
    );

endmodule

// File: logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic               clk,
    input  logic               rst,
    decode_bus_if.execute      dec_i,
    reg_read_if.reader         rd_o,
    output logic               we_o,
    output rv_pkg::reg_addr_t  waddr_o,
    output rv_pkg::xlen_t      wdata_o
);
    import rv_pkg::*;

    xlen_t rs1_val;
    xlen_t rs2_val;
    xlen_t imm_sext;
    xlen_t alu_result;

    assign rd_o.rs1_addr = dec_i.rs1;
    assign rd_o.rs2_addr = dec_i.rs2;

    // Bypass from the result register, which the file has not seen yet
    assign rs1_val = (we_o && (waddr_o == dec_i.rs1)) ? wdata_o : rd_o.rs1_data;
    assign rs2_val = (we_o && (waddr_o == dec_i.rs2)) ? wdata_o : rd_o.rs2_data;

    assign imm_sext = {{32{dec_i.imm[31]}}, dec_i.imm};

    rv_alu u_alu (
        .rs1_i      (rs1_val),
        .rs2_i      (rs2_val),
        .imm_i      (imm_sext),
        .use_imm_i  (dec_i.use_imm),
        .alu_op_i   (dec_i.alu_op),
        .shift_op_i (dec_i.shift_op),
        .cmp_op_i   (dec_i.cmp_op),
        .word_i     (dec_i.word),
        .result_o   (alu_result)
    );

    // Result register doubles as the writeback port
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            we_o <= 1'b0;
        end else begin
            we_o <= dec_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        waddr_o <= dec_i.rd;
        wdata_o <= alu_result;
    end

endmodule

// File: logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    reg_read_if.file          rd_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::xlen_t     wdata_i
);
    import rv_pkg::*;

    // x0 has no storage
    xlen_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rd_i.rs1_data = (rd_i.rs1_addr == '0) ? '0 : regs[rd_i.rs1_addr];
    assign rd_i.rs2_data = (rd_i.rs2_addr == '0) ? '0 : regs[rd_i.rs2_addr];

endmodule

// File: logic/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid_i,
    input  rv_pkg::instr_t       instr_i,
    decode_bus_if.decode         dec_o
);
    import rv_pkg::*;

    instr_t    instr_q;
    logic      instr_valid_q;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    imm_t       iimm;
    imm_t       uimm;

    logic      supported;
    reg_addr_t rs1_d;
    alu_op_e   alu_op_d;
    shift_op_e shift_op_d;
    cmp_op_e   cmp_op_d;
    logic      word_d;
    logic      use_imm_d;
    imm_t      imm_d;

    // Instruction capture on the strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= instr_i;
    end

    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign rd     = instr_q[11:7];
    assign iimm   = {{20{instr_q[31]}}, instr_q[31:20]};
    assign uimm   = {instr_q[31:12], 12'b0};

    //////////////////////////////////////////////////
    // Decode table
    //////////////////////////////////////////////////

    always_comb begin
        supported  = 1'b0;
        rs1_d      = instr_q[19:15];
        alu_op_d   = ALU_ADD;
        shift_op_d = SHIFT_SLL;
        cmp_op_d   = CMP_LT;
        word_d     = 1'b0;
        use_imm_d  = 1'b1;
        imm_d      = iimm;

        unique case (opcode)
            OPCODE_LUI: begin
                // Add of x0 and the U immediate
                supported = 1'b1;
                rs1_d     = '0;
                imm_d     = uimm;
            end
            OPCODE_OP_IMM: begin
                supported = 1'b1;
                unique case (funct3)
                    3'b000: alu_op_d = ALU_ADD;
                    3'b010: alu_op_d = ALU_SLT;
                    3'b011: begin
                        alu_op_d = ALU_SLT;
                        cmp_op_d = CMP_LTU;
                    end
                    3'b100: alu_op_d = ALU_XOR;
                    3'b110: alu_op_d = ALU_OR;
                    3'b111: alu_op_d = ALU_AND;
                    3'b001: begin
                        alu_op_d  = ALU_SHIFT;
                        supported = (funct7[6:1] == 6'b000000);
                    end
                    default: begin
                        // Bit 30 picks SRAI, bit 25 is shamt[5]
                        alu_op_d   = ALU_SHIFT;
                        shift_op_d = funct7[5] ? SHIFT_SRA : SHIFT_SRL;
                        supported  = ({funct7[6], funct7[4:1]} == 5'b00000);
                    end
                endcase
            end
            OPCODE_OP_IMM_32: begin
                word_d = 1'b1;
                unique case (funct3)
                    3'b000: supported = 1'b1;
                    3'b001: begin
                        alu_op_d  = ALU_SHIFT;
                        supported = (funct7 == 7'b0000000);
                    end
                    3'b101: begin
                        alu_op_d   = ALU_SHIFT;
                        shift_op_d = funct7[5] ? SHIFT_SRA : SHIFT_SRL;
                        supported  = ({funct7[6], funct7[4:0]} == 6'b000000);
                    end
                    default: ;
                endcase
            end
            OPCODE_OP, OPCODE_OP_32: begin
                use_imm_d = 1'b0;
                word_d    = (opcode == OPCODE_OP_32);
                supported = 1'b1;
                unique case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op_d = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op_d = ALU_SUB;
                    {7'b0000000, 3'b001}: alu_op_d = ALU_SHIFT;
                    {7'b0000000, 3'b101}: begin
                        alu_op_d   = ALU_SHIFT;
                        shift_op_d = SHIFT_SRL;
                    end
                    {7'b0100000, 3'b101}: begin
                        alu_op_d   = ALU_SHIFT;
                        shift_op_d = SHIFT_SRA;
                    end
                    {7'b0000000, 3'b010}: begin
                        alu_op_d  = ALU_SLT;
                        supported = !word_d;
                    end
                    {7'b0000000, 3'b011}: begin
                        alu_op_d  = ALU_SLT;
                        cmp_op_d  = CMP_LTU;
                        supported = !word_d;
                    end
                    {7'b0000000, 3'b100}: begin
                        alu_op_d  = ALU_XOR;
                        supported = !word_d;
                    end
                    {7'b0000000, 3'b110}: begin
                        alu_op_d  = ALU_OR;
                        supported = !word_d;
                    end
                    {7'b0000000, 3'b111}: begin
                        alu_op_d  = ALU_AND;
                        supported = !word_d;
                    end
                    default: supported = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Decode register
    //////////////////////////////////////////////////

    // Anything that does not write a real register leaves as a bubble
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= instr_valid_q && supported && (rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        dec_o.rd       <= rd;
        dec_o.rs1      <= rs1_d;
        dec_o.rs2      <= instr_q[24:20];
        dec_o.alu_op   <= alu_op_d;
        dec_o.shift_op <= shift_op_d;
        dec_o.cmp_op   <= cmp_op_d;
        dec_o.word     <= word_d;
        dec_o.use_imm  <= use_imm_d;
        dec_o.imm      <= imm_d;
    end

endmodule

// File: logic/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::xlen_t     rs1_i,
    input  rv_pkg::xlen_t     rs2_i,
    input  rv_pkg::xlen_t     imm_i,
    input  logic              use_imm_i,
    input  rv_pkg::alu_op_e   alu_op_i,
    input  rv_pkg::shift_op_e shift_op_i,
    input  rv_pkg::cmp_op_e   cmp_op_i,
    input  logic              word_i,
    output rv_pkg::xlen_t     result_o
);
    import rv_pkg::*;

    xlen_t operand_b;
    xlen_t sum;
    xlen_t difference;
    xlen_t shift_result;
    xlen_t alu_result;
    logic  lt_flag;
    logic  ltu_flag;
    logic  slt_bit;

    assign operand_b  = use_imm_i ? imm_i : rs2_i;
    assign sum        = rs1_i + operand_b;
    assign difference = rs1_i - operand_b;

    //////////////////////////////////////////////////
    // Set-less-than compare
    //////////////////////////////////////////////////

    // Equal top bits: the sign of the difference decides
    // Different top bits: signed picks the negative one as smaller
    assign lt_flag  = (rs1_i[63] == operand_b[63]) ? difference[63] : rs1_i[63];
    // Unsigned picks the one with a clear top bit as smaller
    assign ltu_flag = (rs1_i[63] == operand_b[63]) ? difference[63] : operand_b[63];
    assign slt_bit  = (cmp_op_i == CMP_LTU) ? ltu_flag : lt_flag;

    rv_shifter u_shifter (
        .operand_i  (rs1_i),
        .shamt_i    (operand_b[5:0]),
        .shift_op_i (shift_op_i),
        .word_i     (word_i),
        .result_o   (shift_result)
    );

    // Result mux
    always_comb begin
        unique case (alu_op_i)
            ALU_ADD:   alu_result = sum;
            ALU_SUB:   alu_result = difference;
            ALU_AND:   alu_result = rs1_i & operand_b;
            ALU_OR:    alu_result = rs1_i | operand_b;
            ALU_XOR:   alu_result = rs1_i ^ operand_b;
            ALU_SHIFT: alu_result = shift_result;
            ALU_SLT:   alu_result = {63'b0, slt_bit};
            default:   alu_result = sum;
        endcase
    end

    // Word ops keep the low half, sign extended
    assign result_o = word_i ? {{32{alu_result[31]}}, alu_result[31:0]} : alu_result;

endmodule

// File: logic/rv_shifter.sv
`timescale 1ns/1ps

module rv_shifter (
    input  rv_pkg::xlen_t     operand_i,
    input  logic [5:0]        shamt_i,
    input  rv_pkg::shift_op_e shift_op_i,
    input  logic              word_i,
    output rv_pkg::xlen_t     result_o
);
    import rv_pkg::*;

    xlen_t       shift_in;
    xlen_t       reversed;
    logic        fill_bit;
    logic [5:0]  shamt;
    logic [64:0] shift_ext;
    logic [64:0] shift_out;

    // Left shift goes through the right shifter bit-reversed
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            reversed[i] = operand_i[XLEN-1-i];
        end
    end

    // Right word shift puts the low half on top, padded below
    assign shift_in  = !shift_op_i[0] ? reversed :
                       word_i         ? {operand_i[31:0], 32'b0} : operand_i;
    assign fill_bit  = shift_op_i[1] && shift_in[XLEN-1];
    assign shamt     = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;
    assign shift_ext = {fill_bit, shift_in};
    assign shift_out = $signed(shift_ext) >>> shamt;

    always_comb begin
        if (!shift_op_i[0]) begin
            for (int i = 0; i < XLEN; i++) begin
                result_o[i] = shift_out[XLEN-1-i];
            end
        end else if (word_i) begin
            result_o = {{32{shift_out[63]}}, shift_out[63:32]};
        end else begin
            result_o = shift_out[63:0];
        end
    end

endmodule

// File: logic/pipe_ifs.sv
`timescale 1ns/1ps

// Decoded instruction slot, decode stage to execute stage
interface decode_bus_if;
    import rv_pkg::*;

    logic      valid;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    alu_op_e   alu_op;
    shift_op_e shift_op;
    cmp_op_e   cmp_op;
    logic      word;
    logic      use_imm;
    imm_t      imm;

    modport decode (
        output valid, rd, rs1, rs2, alu_op, shift_op, cmp_op, word, use_imm, imm
    );

    modport execute (
        input valid, rd, rs1, rs2, alu_op, shift_op, cmp_op, word, use_imm, imm
    );
endinterface

// Two combinational read ports of the register file
interface reg_read_if;
    import rv_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    modport reader (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
    modport file (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// File: logic/rv_pkg.sv
package rv_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     imm_t;

    //////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////

    localparam logic [6:0] OPCODE_LUI       = 7'b0110111;
    localparam logic [6:0] OPCODE_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPCODE_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPCODE_OP        = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_32     = 7'b0111011;

    //////////////////////////////////////////////////
    // Operation encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHIFT,
        ALU_SLT
    } alu_op_e;

    // Bit 0 set for right shifts, bit 1 set for arithmetic
    typedef enum logic [1:0] {
        SHIFT_SLL = 2'b00,
        SHIFT_SRL = 2'b01,
        SHIFT_SRA = 2'b11
    } shift_op_e;

    typedef enum logic {
        CMP_LT  = 1'b0,
        CMP_LTU = 1'b1
    } cmp_op_e;

endpackage
